// File: Makefile
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
core_pkg.sv
decode_stage.sv
rename_stage.sv
exec_stage.sv
retire_stage.sv
core.sv
core_chk.sv
core_tb.sv

// File: core.sv
// four stage in-order core, decode to retire; strobe at edge k retires after edge k+4
module core (
	input                                   clk,
	input                                   reset_i,
	input  logic                            inst_vld_i,
	input  core_pkg::instr_u                inst_i,
	output logic                            retire_vld_o,
	output logic [core_pkg::AREG_IDX_W-1:0] retire_areg_o,
	output logic [core_pkg::WORD_W-1:0]     retire_val_o,
	output logic                            halt_o,
	output core_pkg::core_status_e          status_o
);
	import core_pkg::*;

	dec_inst_t             dec;         // decode -> rename
	ren_inst_t             ren;         // rename -> execute
	exe_res_t              res;         // execute -> retire
	logic                  free_en;     // retire -> rename reclaim
	logic [PREG_IDX_W-1:0] free_preg;

	//==================================================
	// pipeline
	//==================================================
	decode_stage u_decode (
		.clk        (clk),
		.reset_i    (reset_i),
		.inst_vld_i (inst_vld_i),
		.inst_i     (inst_i),
		.dec_o      (dec)
	);

	rename_stage u_rename (
		.clk         (clk),
		.reset_i     (reset_i),
		.dec_i       (dec),
		.free_en_i   (free_en),
		.free_preg_i (free_preg),
		.ren_o       (ren)
	);

	exec_stage u_exec (
		.clk     (clk),
		.reset_i (reset_i),
		.ren_i   (ren),
		.res_o   (res)
	);

	retire_stage u_retire (
		.clk           (clk),
		.reset_i       (reset_i),
		.res_i         (res),
		.retire_vld_o  (retire_vld_o),
		.retire_areg_o (retire_areg_o),
		.retire_val_o  (retire_val_o),
		.halt_o        (halt_o),
		.status_o      (status_o),
		.free_en_o     (free_en),     // reclaim loop
		.free_preg_o   (free_preg)
	);

endmodule

// File: core_chk.sv
// bound into core; checks only the status and retire strobe relations, not values
module core_chk (
	input logic                   clk,
	input logic                   reset_i,
	input logic                   retire_vld_o,
	input logic                   halt_o,
	input core_pkg::core_status_e status_o
);
	timeunit 1ns;
	timeprecision 100ps;
	import core_pkg::*;

	//==================================================
	// sticky halt rules
	//==================================================
	// nothing retires once halted
	no_retire_halted: assert property (@(posedge clk) disable iff (reset_i)
		!(retire_vld_o && halt_o))
		else $error("retire strobe while halt_o is high");

	halt_sticky: assert property (@(posedge clk) disable iff (reset_i)
		!$fell(halt_o))   // only reset clears it
		else $error("halt_o fell outside reset");

	// error code only together with halt
	status_clean: assert property (@(posedge clk) disable iff (reset_i)
		halt_o || status_o == NO_ERROR)
		else $error("status_o not NO_ERROR while running");

endmodule

// File: core_pkg.sv
// integer operate subset of the alpha ISA only; no memory, branch or PAL formats beyond halt
package core_pkg;

	//==================================================
	// widths and sizes
	//==================================================
	localparam int AREG_NUM   = 32;   // architectural regs
	localparam int PREG_NUM   = 64;   // physical regs
	localparam int AREG_IDX_W = 5;
	localparam int PREG_IDX_W = 6;
	localparam int FL_PTR_W   = 5;    // free list holds PREG_NUM-AREG_NUM tags
	localparam int WORD_W     = 64;

	localparam logic [AREG_IDX_W-1:0] ZERO_REG = 5'd31;   // reads zero, never renamed

	//==================================================
	// encodings
	//==================================================
	localparam logic [5:0] OP_PAL  = 6'h00;
	localparam logic [5:0] OP_INTA = 6'h10;   // add, sub, compare
	localparam logic [5:0] OP_INTL = 6'h11;   // logical
	localparam logic [5:0] OP_INTS = 6'h12;   // shifts

	localparam logic [6:0] FN_ADDQ   = 7'h20;
	localparam logic [6:0] FN_SUBQ   = 7'h29;
	localparam logic [6:0] FN_CMPEQ  = 7'h2d;
	localparam logic [6:0] FN_CMPULT = 7'h1d;
	localparam logic [6:0] FN_AND    = 7'h00;
	localparam logic [6:0] FN_BIS    = 7'h20;   // same code as addq, other opcode
	localparam logic [6:0] FN_XOR    = 7'h40;
	localparam logic [6:0] FN_SLL    = 7'h39;
	localparam logic [6:0] FN_SRL    = 7'h34;

	typedef enum logic [3:0] {
		ALU_ADDQ, ALU_SUBQ, ALU_CMPEQ, ALU_CMPULT,
		ALU_AND, ALU_BIS, ALU_XOR, ALU_SLL, ALU_SRL
	} alu_op_e;

	typedef enum logic [3:0] {
		NO_ERROR          = 4'h0,
		HALTED_ON_HALT    = 4'h2,
		HALTED_ON_ILLEGAL = 4'h3
	} core_status_e;

	//==================================================
	// instruction word, two views of operate format
	//==================================================
	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic [4:0] ra;
			logic [4:0] rb;
			logic [2:0] sbz;        // should be zero
			logic       lit_flag;   // 0 here
			logic [6:0] func;
			logic [4:0] rc;
		} reg_fmt;
		struct packed {
			logic [5:0] opcode;
			logic [4:0] ra;
			logic [7:0] lit;        // zero extended
			logic       lit_flag;   // 1 here
			logic [6:0] func;
			logic [4:0] rc;
		} lit_fmt;
	} instr_u;

	//==================================================
	// stage records
	//==================================================
	typedef struct packed {
		logic                  valid;
		logic [AREG_IDX_W-1:0] ra;
		logic [AREG_IDX_W-1:0] rb;
		logic [AREG_IDX_W-1:0] rc;
		logic                  use_lit;
		logic [7:0]            literal;
		alu_op_e               alu_op;
		logic                  halt;
		logic                  illegal;
	} dec_inst_t;

	typedef struct packed {
		logic                  valid;
		logic                  use_lit;
		logic [7:0]            literal;
		alu_op_e               alu_op;
		logic                  halt;
		logic                  illegal;
		logic [PREG_IDX_W-1:0] opa;        // source tags
		logic [PREG_IDX_W-1:0] opb;
		logic [PREG_IDX_W-1:0] dest;       // new tag
		logic [PREG_IDX_W-1:0] old_dest;   // freed at retire
		logic [AREG_IDX_W-1:0] areg_dest;
		logic                  writes_dest;
	} ren_inst_t;

	typedef struct packed {
		logic                  valid;
		logic                  halt;
		logic                  illegal;
		logic                  writes_dest;
		logic [AREG_IDX_W-1:0] areg_dest;
		logic [PREG_IDX_W-1:0] old_dest;
		logic [WORD_W-1:0]     value;
	} exe_res_t;

endpackage

// File: core_tb.sv
// needs a simulator with timing support; assumes retire four clocks after each strobe, no stall
module core_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import core_pkg::*;

	typedef struct packed {
		logic [4:0]  areg;
		logic [63:0] value;
		logic [31:0] cyc;   // clock count when the retire is due
	} exp_t;

	logic         clk;
	logic         reset_i;
	logic         inst_vld_i;
	instr_u       inst_i;
	logic         retire_vld_o;
	logic [4:0]   retire_areg_o;
	logic [63:0]  retire_val_o;
	logic         halt_o;
	core_status_e status_o;

	logic [63:0] arch_q [32];   // reference register file, r31 never written
	bit          halted;        // reference stops after halt or illegal
	exp_t        exp_q [$];
	int          cyc = 0;
	int          errors = 0;
	int          checks = 0;
	int          tests = 0;
	int          failed = 0;
	int          err_mark;
	string       cur_test;

	core uut (
		.clk           (clk),
		.reset_i       (reset_i),
		.inst_vld_i    (inst_vld_i),
		.inst_i        (inst_i),
		.retire_vld_o  (retire_vld_o),
		.retire_areg_o (retire_areg_o),
		.retire_val_o  (retire_val_o),
		.halt_o        (halt_o),
		.status_o      (status_o)
	);

	bind core core_chk u_chk (
		.clk          (clk),
		.reset_i      (reset_i),
		.retire_vld_o (retire_vld_o),
		.halt_o       (halt_o),
		.status_o     (status_o)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;   // 20 ns period
	end

	always @(posedge clk) cyc <= cyc + 1;

	//==================================================
	// reference model and encoder
	//==================================================
	function automatic bit predict(input logic [31:0] w, output logic [4:0] areg,
			output logic [63:0] val);
		logic [5:0]  op;
		logic [6:0]  fn;
		logic [63:0] a;
		logic [63:0] b;
		op   = w[31:26];
		fn   = w[11:5];
		areg = w[4:0];
		val  = '0;
		a    = arch_q[w[25:21]];
		b    = w[12] ? {56'b0, w[20:13]} : arch_q[w[20:16]];   // literal is zero extended
		if (halted) return 1'b0;   // silent after halt
		case ({op, fn})
			{6'h10, 7'h20}: val = a + b;
			{6'h10, 7'h29}: val = a - b;
			{6'h10, 7'h2d}: val = {63'b0, a == b};
			{6'h10, 7'h1d}: val = {63'b0, a < b};   // unsigned
			{6'h11, 7'h00}: val = a & b;
			{6'h11, 7'h20}: val = a | b;
			{6'h11, 7'h40}: val = a ^ b;
			{6'h12, 7'h39}: val = a << b[5:0];
			{6'h12, 7'h34}: val = a >> b[5:0];
			default: begin
				halted = 1'b1;   // halt or illegal, no report
				return 1'b0;
			end
		endcase
		if (areg != 5'd31) arch_q[areg] = val;
		return 1'b1;
	endfunction

	// alpha operate format, op index 0..8 as in the reference
	function automatic logic [31:0] encode(input int op, input logic [4:0] ra,
			input logic [4:0] rb, input logic [7:0] lit, input bit use_lit, input logic [4:0] rc);
		logic [12:0] opfn;
		case (op)
			0: opfn = {6'h10, 7'h20};   // addq
			1: opfn = {6'h10, 7'h29};   // subq
			2: opfn = {6'h10, 7'h2d};   // cmpeq
			3: opfn = {6'h10, 7'h1d};   // cmpult
			4: opfn = {6'h11, 7'h00};   // and
			5: opfn = {6'h11, 7'h20};   // bis
			6: opfn = {6'h11, 7'h40};   // xor
			7: opfn = {6'h12, 7'h39};   // sll
			default: opfn = {6'h12, 7'h34};   // srl
		endcase
		if (use_lit) return {opfn[12:7], ra, lit, 1'b1, opfn[6:0], rc};
		return {opfn[12:7], ra, rb, 3'b000, 1'b0, opfn[6:0], rc};
	endfunction

	function automatic logic [4:0] rnd_reg();
		return 5'($urandom_range(30, 0));
	endfunction

	//==================================================
	// drive tasks, all start and end 2 ns after an edge
	//==================================================
	task automatic do_reset();
		reset_i    = 1'b1;
		inst_vld_i = 1'b0;
		repeat (5) @(posedge clk);
		#2;
		reset_i = 1'b0;
		for (int i = 0; i < 32; i++) arch_q[i] = '0;
		halted = 1'b0;
		exp_q.delete();
	endtask

	task automatic issue(input logic [31:0] w);
		logic [4:0]  a;
		logic [63:0] v;
		exp_t        e;
		inst_vld_i = 1'b1;
		inst_i     = w;
		if (predict(w, a, v)) begin
			e.areg  = a;
			e.value = v;
			e.cyc   = 32'(cyc + 5);   // sampled next edge, four stages after that
			exp_q.push_back(e);
		end
		@(posedge clk);
		#2;
	endtask

	task automatic idle();
		inst_vld_i = 1'b0;
		inst_i     = $urandom;   // junk payload with strobe low
		@(posedge clk);
		#2;
	endtask

	task automatic drain();
		int t;
		t          = 0;
		inst_vld_i = 1'b0;
		while (exp_q.size() != 0 && t < 50) begin
			@(posedge clk);
			#2;
			t++;
		end
		if (exp_q.size() != 0) begin
			$display("%s: timed out waiting for %0d retires", cur_test, exp_q.size());
			errors++;
			exp_q.delete();
		end
	endtask

	task automatic wait_halt();
		int t;
		t          = 0;
		inst_vld_i = 1'b0;
		while (halt_o !== 1'b1 && t < 20) begin
			@(posedge clk);
			#2;
			t++;
		end
		if (halt_o !== 1'b1) begin
			$display("%s: halt_o never rose", cur_test);
			errors++;
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		err_mark = errors;
	endtask

	task automatic end_test();
		tests++;
		if (errors == err_mark) begin
			$display("test %s: pass", cur_test);
		end else begin
			failed++;
			$display("test %s: fail, %0d errors", cur_test, errors - err_mark);
		end
	endtask

	//==================================================
	// compare process, samples on the falling edge
	//==================================================
	initial begin
		exp_t e;
		forever begin
			@(negedge clk);
			if (!reset_i && retire_vld_o) begin
				if (exp_q.size() == 0) begin
					$display("%s: unexpected retire of r%0d", cur_test, retire_areg_o);
					errors++;
				end else begin
					e = exp_q.pop_front();
					checks++;
					if (retire_areg_o !== e.areg) begin
						$display("error %s areg expected %0d actual %0d", cur_test, e.areg,
							retire_areg_o);
						errors++;
					end
					if (retire_val_o !== e.value) begin
						$display("error %s value expected %h actual %h", cur_test, e.value,
							retire_val_o);
						errors++;
					end
					if (cyc != int'(e.cyc)) begin
						$display("error %s retire cycle expected %0d actual %0d", cur_test,
							e.cyc, cyc);
						errors++;
					end
				end
			end
		end
	end

	//==================================================
	// test sequence
	//==================================================
	initial begin
		logic [4:0] prev;
		logic [4:0] dst;
		reset_i    = 1'b1;
		inst_vld_i = 1'b0;
		inst_i     = '0;
		void'($urandom(72200));
		do_reset();

		start_test("reset_state");
		repeat (4) begin
			if (retire_vld_o !== 1'b0 || halt_o !== 1'b0 || status_o !== NO_ERROR) begin
				$display("%s: outputs active after reset", cur_test);
				errors++;
			end
			idle();
		end
		end_test();

		start_test("all_ops");
		for (int r = 0; r < 31; r++) begin   // fill regs with wide values
			issue(encode(5, 5'd31, 5'd0, 8'($urandom), 1'b1, 5'(r)));
			issue(encode(7, 5'(r), 5'd0, 8'($urandom), 1'b1, 5'(r)));
		end
		for (int op = 0; op < 9; op++) begin
			issue(encode(op, rnd_reg(), rnd_reg(), 8'd0, 1'b0, rnd_reg()));
			issue(encode(op, rnd_reg(), 5'd0, 8'($urandom), 1'b1, rnd_reg()));
		end
		drain();
		end_test();

		start_test("dependent_chain");
		prev = rnd_reg();
		for (int i = 0; i < 24; i++) begin
			dst = rnd_reg();
			issue(encode(i % 9, prev, rnd_reg(), 8'($urandom), 1'(i / 2), dst));
			prev = dst;
		end
		drain();
		end_test();

		start_test("random_stream");
		for (int i = 0; i < 300; i++) begin
			if ($urandom_range(3, 0) == 0) idle();   // bubble
			issue(encode(int'($urandom_range(8, 0)), 5'($urandom), 5'($urandom),
				8'($urandom), 1'($urandom), 5'($urandom)));
		end
		drain();
		end_test();

		start_test("halt");
		do_reset();
		issue(encode(0, 5'd31, 5'd0, 8'd7, 1'b1, 5'd3));
		issue(encode(0, 5'd3, 5'd3, 8'd0, 1'b0, 5'd4));
		issue(32'h0000_0000);   // pal function zero
		for (int i = 0; i < 3; i++) issue(encode(i, rnd_reg(), rnd_reg(), 8'd0, 1'b0, rnd_reg()));
		drain();
		wait_halt();
		if (status_o !== HALTED_ON_HALT) begin
			$display("error %s status expected HALTED_ON_HALT actual %s", cur_test,
				status_o.name());
			errors++;
		end
		repeat (10) idle();   // stray retires caught by compare process
		if (halt_o !== 1'b1) begin
			$display("%s: halt_o dropped without reset", cur_test);
			errors++;
		end
		end_test();

		start_test("illegal");
		do_reset();
		issue(encode(0, 5'd31, 5'd0, 8'd9, 1'b1, 5'd1));
		issue({6'h08, 26'h0});   // load format, not supported
		issue(encode(0, 5'd1, 5'd1, 8'd0, 1'b0, 5'd2));
		drain();
		wait_halt();
		if (status_o !== HALTED_ON_ILLEGAL) begin
			$display("error %s status expected HALTED_ON_ILLEGAL actual %s", cur_test,
				status_o.name());
			errors++;
		end
		repeat (6) idle();
		end_test();

		$display("tests %0d, failed %0d, retires checked %0d, errors %0d", tests, failed,
			checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: decode_stage.sv
// no back-pressure, one word per clock; anything outside the operate subset is flagged illegal
module decode_stage (
	input                      clk,
	input                      reset_i,
	input  logic               inst_vld_i,
	input  core_pkg::instr_u   inst_i,
	output core_pkg::dec_inst_t dec_o
);
	import core_pkg::*;

	logic      vld_q;    // sampled strobe
	instr_u    inst_q;   // sampled word
	dec_inst_t dec_d;

	//==================================================
	// input capture
	//==================================================
	always_ff @(posedge clk) begin
		if (reset_i) begin
			vld_q <= 1'b0;
		end else begin
			vld_q <= inst_vld_i;
		end
		inst_q <= inst_i;   // payload only
	end

	//==================================================
	// field extract and classify
	//==================================================
	always_comb begin
		dec_d         = '0;
		dec_d.valid   = vld_q;
		dec_d.ra      = inst_q.reg_fmt.ra;
		dec_d.rc      = inst_q.reg_fmt.rc;
		dec_d.use_lit = inst_q.reg_fmt.lit_flag;
		dec_d.alu_op  = ALU_ADDQ;
		// view picked by literal flag
		if (inst_q.reg_fmt.lit_flag) begin
			dec_d.literal = inst_q.lit_fmt.lit;
			dec_d.rb      = ZERO_REG;   // harmless read
		end else begin
			dec_d.rb = inst_q.reg_fmt.rb;
		end

		case (inst_q.reg_fmt.opcode)
			OP_PAL: begin
				if (inst_q.reg_fmt.func == 7'h00) dec_d.halt = 1'b1;
				else dec_d.illegal = 1'b1;   // other pal calls unsupported
			end
			OP_INTA: begin
				case (inst_q.reg_fmt.func)
					FN_ADDQ:   dec_d.alu_op = ALU_ADDQ;
					FN_SUBQ:   dec_d.alu_op = ALU_SUBQ;
					FN_CMPEQ:  dec_d.alu_op = ALU_CMPEQ;
					FN_CMPULT: dec_d.alu_op = ALU_CMPULT;
					default:   dec_d.illegal = 1'b1;
				endcase
			end
			OP_INTL: begin
				case (inst_q.reg_fmt.func)
					FN_AND:  dec_d.alu_op = ALU_AND;
					FN_BIS:  dec_d.alu_op = ALU_BIS;
					FN_XOR:  dec_d.alu_op = ALU_XOR;
					default: dec_d.illegal = 1'b1;
				endcase
			end
			OP_INTS: begin
				case (inst_q.reg_fmt.func)
					FN_SLL:  dec_d.alu_op = ALU_SLL;
					FN_SRL:  dec_d.alu_op = ALU_SRL;
					default: dec_d.illegal = 1'b1;
				endcase
			end
			default: dec_d.illegal = 1'b1;   // loads, stores, branches, fp
		endcase

		// status flags only mean something on a live slot
		if (!vld_q) begin
			dec_d.halt    = 1'b0;
			dec_d.illegal = 1'b0;
		end
	end

	// output register
	always_ff @(posedge clk) begin
		if (reset_i) begin
			dec_o.valid <= 1'b0;
		end else begin
			dec_o <= dec_d;
		end
	end

endmodule

// File: exec_stage.sv
// register file written at end of execute and read in the same cycle; no bypass exists
module exec_stage (
	input                           clk,
	input                           reset_i,
	input  core_pkg::ren_inst_t     ren_i,
	output core_pkg::exe_res_t      res_o
);
	import core_pkg::*;

	logic [WORD_W-1:0] prf_q [PREG_NUM];   // physical register file
	logic [WORD_W-1:0] opa_val;
	logic [WORD_W-1:0] opb_val;
	logic [WORD_W-1:0] alu_out;
	logic              wr_en;
	exe_res_t          res_d;

	//==================================================
	// operand read
	//==================================================
	// preg 31 stays zero since it is never handed out
	assign opa_val = prf_q[ren_i.opa];
	assign opb_val = ren_i.use_lit ? WORD_W'(ren_i.literal) : prf_q[ren_i.opb];

	//==================================================
	// integer alu
	//==================================================
	always_comb begin
		case (ren_i.alu_op)
			ALU_ADDQ:   alu_out = opa_val + opb_val;
			ALU_SUBQ:   alu_out = opa_val - opb_val;
			ALU_CMPEQ:  alu_out = WORD_W'(opa_val == opb_val);   // 1 or 0
			ALU_CMPULT: alu_out = WORD_W'(opa_val < opb_val);    // unsigned
			ALU_AND:    alu_out = opa_val & opb_val;
			ALU_BIS:    alu_out = opa_val | opb_val;
			ALU_XOR:    alu_out = opa_val ^ opb_val;
			ALU_SLL:    alu_out = opa_val << opb_val[5:0];   // low six bits only
			ALU_SRL:    alu_out = opa_val >> opb_val[5:0];
			default:    alu_out = '0;
		endcase
	end

	assign wr_en = ren_i.valid & ren_i.writes_dest;

	always_comb begin
		res_d             = '0;
		res_d.valid       = ren_i.valid;
		res_d.halt        = ren_i.halt;
		res_d.illegal     = ren_i.illegal;
		res_d.writes_dest = ren_i.writes_dest;
		res_d.areg_dest   = ren_i.areg_dest;
		res_d.old_dest    = ren_i.old_dest;
		res_d.value       = alu_out;
	end

	//==================================================
	// writeback and result register
	//==================================================
	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < PREG_NUM; i++) begin
				prf_q[i] <= '0;   // all values start at zero
			end
			res_o.valid <= 1'b0;
		end else begin
			if (wr_en) begin
				prf_q[ren_i.dest] <= alu_out;
			end
			res_o <= res_d;
		end
	end

endmodule

// File: rename_stage.sv
// free list never runs dry with at most four in flight, so no empty check and no stall
module rename_stage (
	input                                   clk,
	input                                   reset_i,
	input  core_pkg::dec_inst_t             dec_i,
	input  logic                            free_en_i,
	input  logic [core_pkg::PREG_IDX_W-1:0] free_preg_i,
	output core_pkg::ren_inst_t             ren_o
);
	import core_pkg::*;

	localparam int FL_DEPTH = PREG_NUM - AREG_NUM;   // spare tags

	logic [PREG_IDX_W-1:0] map_q  [AREG_NUM];   // areg -> preg
	logic [PREG_IDX_W-1:0] free_q [FL_DEPTH];   // circular free list
	logic [FL_PTR_W-1:0]   head_q;              // next tag to hand out
	logic [FL_PTR_W-1:0]   tail_q;              // next reclaim slot
	logic                  alloc;
	ren_inst_t             ren_d;

	// halt, illegal and r31 targets take no tag
	assign alloc = dec_i.valid & ~dec_i.halt & ~dec_i.illegal & (dec_i.rc != ZERO_REG);

	//==================================================
	// lookup
	//==================================================
	always_comb begin
		ren_d             = '0;
		ren_d.valid       = dec_i.valid;
		ren_d.use_lit     = dec_i.use_lit;
		ren_d.literal     = dec_i.literal;
		ren_d.alu_op      = dec_i.alu_op;
		ren_d.halt        = dec_i.halt;
		ren_d.illegal     = dec_i.illegal;
		ren_d.opa         = map_q[dec_i.ra];
		ren_d.opb         = map_q[dec_i.rb];
		ren_d.areg_dest   = dec_i.rc;   // reported even for r31
		ren_d.writes_dest = alloc;
		ren_d.dest        = free_q[head_q];
		ren_d.old_dest    = map_q[dec_i.rc];   // goes back at retire
	end

	//==================================================
	// map table and free list update
	//==================================================
	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < AREG_NUM; i++) begin
				map_q[i] <= PREG_IDX_W'(i);   // identity mapping
			end
			for (int i = 0; i < FL_DEPTH; i++) begin
				free_q[i] <= PREG_IDX_W'(AREG_NUM + i);   // tags 32..63
			end
			head_q      <= '0;
			tail_q      <= '0;   // full list, head equals tail
			ren_o.valid <= 1'b0;
		end else begin
			if (alloc) begin
				map_q[dec_i.rc] <= free_q[head_q];   // seen by the next word
				head_q          <= head_q + 1'b1;
			end
			if (free_en_i) begin
				free_q[tail_q] <= free_preg_i;   // reclaim from retire
				tail_q         <= tail_q + 1'b1;
			end
			ren_o <= ren_d;
		end
	end

endmodule

// File: retire_stage.sv
// in-order retire, one per clock; after halt or illegal everything is dropped until reset
module retire_stage (
	input                                   clk,
	input                                   reset_i,
	input  core_pkg::exe_res_t              res_i,
	output logic                            retire_vld_o,
	output logic [core_pkg::AREG_IDX_W-1:0] retire_areg_o,
	output logic [core_pkg::WORD_W-1:0]     retire_val_o,
	output logic                            halt_o,
	output core_pkg::core_status_e          status_o,
	output logic                            free_en_o,
	output logic [core_pkg::PREG_IDX_W-1:0] free_preg_o
);
	import core_pkg::*;

	logic live;   // result allowed to retire

	assign live = res_i.valid & ~halt_o;

	//==================================================
	// report, reclaim and sticky status
	//==================================================
	always_ff @(posedge clk) begin
		if (reset_i) begin
			retire_vld_o <= 1'b0;
			free_en_o    <= 1'b0;
			halt_o       <= 1'b0;
			status_o     <= NO_ERROR;
		end else begin
			retire_vld_o <= 1'b0;   // single cycle pulses
			free_en_o    <= 1'b0;
			if (live && (res_i.halt || res_i.illegal)) begin
				halt_o   <= 1'b1;   // stays until reset
				status_o <= res_i.illegal ? HALTED_ON_ILLEGAL : HALTED_ON_HALT;
			end else if (live) begin
				retire_vld_o <= 1'b1;
				free_en_o    <= res_i.writes_dest;   // old tag back to free list
			end
		end
	end

	// payload follows the strobe
	always_ff @(posedge clk) begin
		retire_areg_o <= res_i.areg_dest;
		retire_val_o  <= res_i.value;
		free_preg_o   <= res_i.old_dest;
	end

endmodule
